// File: axi4s_stage_pkg.sv
// Constants shared by the bypass stage
// Beat payload types and the path FSM state encoding

`default_nettype none

package axi4s_stage_pkg;

    // ==============================
    // Stage constants
    // ==============================
    localparam int DATA_BYTE_WID = 4;
    localparam int TUSER_WID     = 4;
    localparam int BYPASS_STAGES = 2;
    localparam int PKT_CNT_WID   = 4;

    // Beat fields
    typedef logic [DATA_BYTE_WID-1:0][7:0] tdata_t;
    typedef logic [DATA_BYTE_WID-1:0]      tkeep_t;
    typedef logic [TUSER_WID-1:0]          tuser_t;

    typedef struct packed {
        tdata_t tdata;
        tkeep_t tkeep;
        logic   tlast;
        tuser_t tuser;
    } beat_t;

    // Path selection states
    typedef enum logic [1:0] {
        PROC,
        DRAIN_TO_BYP,
        BYP,
        DRAIN_TO_PROC
    } path_state_t;

endpackage : axi4s_stage_pkg

`default_nettype wire

// File: axi4s_beat_if.sv
// Valid/ready beat interface
// tx and rx modports for links inside the stage

`timescale 1ns/100ps
`default_nettype none

interface axi4s_beat_if;
    import axi4s_stage_pkg::*;

    logic  tvalid;
    logic  tready;
    beat_t beat;

    // Source side
    modport tx (
        output tvalid,
        output beat,
        input  tready
    );

    // Sink side
    modport rx (
        input  tvalid,
        input  beat,
        output tready
    );

endinterface : axi4s_beat_if

`default_nettype wire

// File: stream_reg_slice.sv
// Forward register slice, pull mode
// One beat of storage, ready while empty or draining

`timescale 1ns/100ps
`default_nettype none

module stream_reg_slice (
    input  logic            axi4s_if_from_tx,
    input  logic            aresetn,
    axi4s_beat_if.rx        up,
    axi4s_beat_if.tx        down
);
    import axi4s_stage_pkg::*;

    beat_t beat_q;
    logic  vld_q;

    // Take a new beat when empty or when the current one leaves
    assign up.tready = !vld_q || down.tready;

    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            vld_q <= 1'b0;
        end else if (up.tready) begin
            vld_q <= up.tvalid;
        end
    end

    // Payload register
    always_ff @(posedge axi4s_if_from_tx) begin
        if (up.tvalid && up.tready) begin
            beat_q <= up.beat;
        end
    end

    assign down.tvalid = vld_q;
    assign down.beat   = beat_q;

endmodule : stream_reg_slice

`default_nettype wire

// File: null_tlast_trimmer.sv
// Null closing beat trimmer
// Holds one beat until its successor is known and folds
// a null tlast beat into the beat before it

`timescale 1ns/100ps
`default_nettype none

module null_tlast_trimmer (
    input  logic            axi4s_if_from_tx,
    input  logic            aresetn,
    axi4s_beat_if.rx        up,
    axi4s_beat_if.tx        down
);
    import axi4s_stage_pkg::*;

    beat_t held_q;
    beat_t out_beat;
    logic  held_vld_q;
    logic  up_xfer;
    logic  down_xfer;
    logic  fold;

    assign up_xfer   = up.tvalid && up.tready;
    assign down_xfer = down.tvalid && down.tready;

    // Null closing beat behind an open held beat
    assign fold = held_vld_q && !held_q.tlast && up.beat.tlast && (up.beat.tkeep == '0);

    // ==============================
    // Release of the held beat
    // ==============================
    // A tlast beat goes out at once, otherwise wait for the next beat
    assign down.tvalid = held_vld_q && (held_q.tlast || up.tvalid);
    assign up.tready   = !held_vld_q || down.tready;

    always_comb begin
        out_beat       = held_q;
        out_beat.tlast = held_q.tlast || fold;
    end

    assign down.beat = out_beat;

    // ==============================
    // Hold register
    // ==============================
    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            held_vld_q <= 1'b0;
        end else if (up_xfer) begin
            // Folded null beat is dropped, anything else is kept
            held_vld_q <= !fold;
        end else if (down_xfer) begin
            held_vld_q <= 1'b0;
        end
    end

    always_ff @(posedge axi4s_if_from_tx) begin
        if (up_xfer && !fold) begin
            held_q <= up.beat;
        end
    end

endmodule : null_tlast_trimmer

`default_nettype wire

// File: inflight_pkt_counter.sv
// Saturating count of packets inside the stage

`timescale 1ns/100ps
`default_nettype none

module inflight_pkt_counter (
    input  logic axi4s_if_from_tx,
    input  logic aresetn,
    input  logic pkt_in,
    input  logic pkt_out,
    output logic empty
);
    import axi4s_stage_pkg::*;

    logic [PKT_CNT_WID-1:0] cnt_q;

    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            cnt_q <= '0;
        end else if (pkt_in && !pkt_out) begin
            // Hold at full scale
            if (cnt_q != '1) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end else if (pkt_out && !pkt_in) begin
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    assign empty = (cnt_q == '0);

endmodule : inflight_pkt_counter

`default_nettype wire

// File: path_select_fsm.sv
// Path select FSM
// Start-of-packet tracking, drain control and packet events
// for the in-flight counter

`timescale 1ns/100ps
`default_nettype none

module path_select_fsm (
    input  logic axi4s_if_from_tx,
    input  logic aresetn,
    input  logic bypass,
    input  logic us_tvalid,
    input  logic us_tready,
    input  logic us_tlast,
    input  logic ds_tvalid,
    input  logic ds_tready,
    input  logic ds_tlast,
    output logic stall,
    output logic bypass_active
);
    import axi4s_stage_pkg::*;

    path_state_t state_q;
    path_state_t state_nxt;
    logic        sop_q;
    logic        change_req;
    logic        pkt_in;
    logic        pkt_out;
    logic        empty;

    // Packet events for the counter
    assign pkt_in  = us_tvalid && us_tready && us_tlast;
    assign pkt_out = ds_tvalid && ds_tready && ds_tlast;

    inflight_pkt_counter u_pkt_cnt (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .pkt_in           (pkt_in),
        .pkt_out          (pkt_out),
        .empty            (empty)
    );

    // Start of packet at the input
    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            sop_q <= 1'b1;
        end else if (us_tvalid && us_tready) begin
            sop_q <= us_tlast;
        end
    end

    // ==============================
    // Path state
    // ==============================
    // Request only counts between packets
    assign change_req = sop_q && (bypass != bypass_active) &&
                        (state_q == PROC || state_q == BYP);

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            PROC:          if (change_req) state_nxt = DRAIN_TO_BYP;
            DRAIN_TO_BYP:  if (empty)      state_nxt = BYP;
            BYP:           if (change_req) state_nxt = DRAIN_TO_PROC;
            DRAIN_TO_PROC: if (empty)      state_nxt = PROC;
            default:                       state_nxt = PROC;
        endcase
    end

    // Reset parks in a drain state so the input stays closed one cycle
    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            state_q       <= DRAIN_TO_PROC;
            bypass_active <= 1'b0;
        end else begin
            state_q       <= state_nxt;
            bypass_active <= (state_nxt == BYP) || (state_nxt == DRAIN_TO_PROC);
        end
    end

    // Input closed while draining or while a change is pending
    assign stall = (state_q == DRAIN_TO_BYP) || (state_q == DRAIN_TO_PROC) || change_req;

endmodule : path_select_fsm

`default_nettype wire

// File: stream_path_mux.sv
// Input steering to one path and output select from it
// Downstream ready goes back only to the active path

`timescale 1ns/100ps
`default_nettype none

module stream_path_mux (
    input  logic     stall,
    input  logic     bypass_active,
    axi4s_beat_if.rx up,
    axi4s_beat_if.tx to_proc,
    axi4s_beat_if.tx to_byp,
    axi4s_beat_if.rx from_proc,
    axi4s_beat_if.rx from_byp,
    axi4s_beat_if.tx down
);
    logic open_in;

    assign open_in = up.tvalid && !stall;

    // ==============================
    // Input steering
    // ==============================
    assign to_proc.tvalid = open_in && !bypass_active;
    assign to_byp.tvalid  = open_in && bypass_active;
    assign to_proc.beat   = up.beat;
    assign to_byp.beat    = up.beat;

    assign up.tready = !stall && (bypass_active ? to_byp.tready : to_proc.tready);

    // ==============================
    // Output select
    // ==============================
    assign down.tvalid = bypass_active ? from_byp.tvalid : from_proc.tvalid;
    assign down.beat   = bypass_active ? from_byp.beat   : from_proc.beat;

    // Inactive path sees ready low
    assign from_proc.tready = !bypass_active && down.tready;
    assign from_byp.tready  = bypass_active && down.tready;

endmodule : stream_path_mux

`default_nettype wire

// File: axi4s_bypass_stage.sv
// Bypass stage top level
// Plain stream ports, path FSM, mux, trimmer and bypass slices

`timescale 1ns/100ps
`default_nettype none

module axi4s_bypass_stage (
    input  logic                    axi4s_if_from_tx,
    input  logic                    aresetn,
    input  logic                    bypass,
    // Upstream
    input  logic                    us_tvalid,
    output logic                    us_tready,
    input  axi4s_stage_pkg::tdata_t us_tdata,
    input  axi4s_stage_pkg::tkeep_t us_tkeep,
    input  logic                    us_tlast,
    input  axi4s_stage_pkg::tuser_t us_tuser,
    // Downstream
    output logic                    ds_tvalid,
    input  logic                    ds_tready,
    output axi4s_stage_pkg::tdata_t ds_tdata,
    output axi4s_stage_pkg::tkeep_t ds_tkeep,
    output logic                    ds_tlast,
    output axi4s_stage_pkg::tuser_t ds_tuser,
    output logic                    bypass_active
);
    import axi4s_stage_pkg::*;

    logic stall;

    axi4s_beat_if in_stage ();
    axi4s_beat_if in_proc ();
    axi4s_beat_if out_proc ();
    axi4s_beat_if in_byp ();
    axi4s_beat_if byp_chain [BYPASS_STAGES] ();
    axi4s_beat_if out_stage ();

    // ==============================
    // Port packing
    // ==============================
    assign in_stage.tvalid     = us_tvalid;
    assign in_stage.beat.tdata = us_tdata;
    assign in_stage.beat.tkeep = us_tkeep;
    assign in_stage.beat.tlast = us_tlast;
    assign in_stage.beat.tuser = us_tuser;
    assign us_tready           = in_stage.tready;

    assign ds_tvalid        = out_stage.tvalid;
    assign ds_tdata         = out_stage.beat.tdata;
    assign ds_tkeep         = out_stage.beat.tkeep;
    assign ds_tlast         = out_stage.beat.tlast;
    assign ds_tuser         = out_stage.beat.tuser;
    assign out_stage.tready = ds_tready;

    path_select_fsm u_fsm (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .bypass           (bypass),
        .us_tvalid        (us_tvalid),
        .us_tready        (us_tready),
        .us_tlast         (us_tlast),
        .ds_tvalid        (ds_tvalid),
        .ds_tready        (ds_tready),
        .ds_tlast         (ds_tlast),
        .stall            (stall),
        .bypass_active    (bypass_active)
    );

    stream_path_mux u_mux (
        .stall         (stall),
        .bypass_active (bypass_active),
        .up            (in_stage),
        .to_proc       (in_proc),
        .to_byp        (in_byp),
        .from_proc     (out_proc),
        .from_byp      (byp_chain[BYPASS_STAGES-1]),
        .down          (out_stage)
    );

    // Processing path
    null_tlast_trimmer u_trim (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .up               (in_proc),
        .down             (out_proc)
    );

    // Bypass path, one slice per stage
    for (genvar i = 0; i < BYPASS_STAGES; i++) begin : g_byp
        if (i == 0) begin : g_first
            stream_reg_slice u_slice (
                .axi4s_if_from_tx (axi4s_if_from_tx),
                .aresetn          (aresetn),
                .up               (in_byp),
                .down             (byp_chain[0])
            );
        end else begin : g_next
            stream_reg_slice u_slice (
                .axi4s_if_from_tx (axi4s_if_from_tx),
                .aresetn          (aresetn),
                .up               (byp_chain[i-1]),
                .down             (byp_chain[i])
            );
        end
    end

endmodule : axi4s_bypass_stage

`default_nettype wire

// File: tb_axi4s_bypass_stage_assert.sv
// Bound checks on the bypass stage ports
// Reset state, trimming, back-pressure and path switching

`timescale 1ns/100ps
`default_nettype none

module tb_axi4s_bypass_stage_assert (
    input logic                    axi4s_if_from_tx,
    input logic                    aresetn,
    input logic                    bypass,
    input logic                    us_tvalid,
    input logic                    us_tready,
    input logic                    us_tlast,
    input logic                    ds_tvalid,
    input logic                    ds_tready,
    input axi4s_stage_pkg::tdata_t ds_tdata,
    input axi4s_stage_pkg::tkeep_t ds_tkeep,
    input logic                    ds_tlast,
    input axi4s_stage_pkg::tuser_t ds_tuser,
    input logic                    bypass_active
);
    int unsigned fail_cnt = 0;
    int          pkts;
    logic        in_sop;
    logic        out_sop;
    logic        out_path;

    // Packets inside the stage and the path of the current output packet
    always_ff @(posedge axi4s_if_from_tx or negedge aresetn) begin
        if (!aresetn) begin
            pkts     <= 0;
            in_sop   <= 1'b1;
            out_sop  <= 1'b1;
            out_path <= 1'b0;
        end else begin
            if (us_tvalid && us_tready) begin
                in_sop <= us_tlast;
            end
            if (ds_tvalid && ds_tready) begin
                if (out_sop) begin
                    out_path <= bypass_active;
                end
                out_sop <= ds_tlast;
            end
            pkts <= pkts + int'(us_tvalid && us_tready && us_tlast)
                         - int'(ds_tvalid && ds_tready && ds_tlast);
        end
    end

    // ==============================
    // Properties
    // ==============================
    a_reset_quiet: assert property (@(posedge axi4s_if_from_tx)
        (!aresetn || $rose(aresetn)) |-> !ds_tvalid && !us_tready && !bypass_active)
        else begin
            fail_cnt++;
            $error("Outputs not idle during or just after reset");
        end

    a_no_null_last: assert property (@(posedge axi4s_if_from_tx) disable iff (!aresetn)
        (ds_tvalid && !bypass_active) |-> !(ds_tlast && ds_tkeep == '0))
        else begin
            fail_cnt++;
            $error("Null closing beat left the processing path");
        end

    a_hold_stable: assert property (@(posedge axi4s_if_from_tx) disable iff (!aresetn)
        (ds_tvalid && !ds_tready) |=>
            ds_tvalid && $stable({ds_tdata, ds_tkeep, ds_tlast, ds_tuser}))
        else begin
            fail_cnt++;
            $error("Output beat changed while downstream was stalled");
        end

    a_switch_empty: assert property (@(posedge axi4s_if_from_tx) disable iff (!aresetn)
        $changed(bypass_active) |-> $past(pkts) == 0)
        else begin
            fail_cnt++;
            $error("Path changed while packets were still inside the stage");
        end

    a_wait_closed: assert property (@(posedge axi4s_if_from_tx) disable iff (!aresetn)
        (in_sop && bypass != bypass_active) |-> !us_tready)
        else begin
            fail_cnt++;
            $error("Input open while a path change was waiting");
        end

    a_one_path: assert property (@(posedge axi4s_if_from_tx) disable iff (!aresetn)
        (ds_tvalid && !out_sop) |-> bypass_active == out_path)
        else begin
            fail_cnt++;
            $error("Output packet mixed beats from both paths");
        end

endmodule : tb_axi4s_bypass_stage_assert

bind axi4s_bypass_stage tb_axi4s_bypass_stage_assert u_assert (
    .axi4s_if_from_tx (axi4s_if_from_tx),
    .aresetn          (aresetn),
    .bypass           (bypass),
    .us_tvalid        (us_tvalid),
    .us_tready        (us_tready),
    .us_tlast         (us_tlast),
    .ds_tvalid        (ds_tvalid),
    .ds_tready        (ds_tready),
    .ds_tdata         (ds_tdata),
    .ds_tkeep         (ds_tkeep),
    .ds_tlast         (ds_tlast),
    .ds_tuser         (ds_tuser),
    .bypass_active    (bypass_active)
);

`default_nettype wire

// File: tb_axi4s_bypass_stage.sv
// Testbench for the AXI4-Stream bypass stage
// Random packets, reference model, scoreboard, per-test report, timeout

`timescale 1ns/100ps
`default_nettype none

module tb_axi4s_bypass_stage;
    import axi4s_stage_pkg::*;

    localparam int N_TESTS      = 4;
    localparam int N_PKTS       = 16;
    localparam int MAX_LEN      = 6;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_CYCLES = 200;
    localparam int MAX_CYCLES   = N_TESTS * N_PKTS * MAX_LEN * 8 + RESET_CYCLES + DRAIN_CYCLES;

    logic        axi4s_if_from_tx;
    logic        aresetn;
    logic        bypass;
    logic        us_tvalid;
    logic        us_tready;
    tdata_t      us_tdata;
    tkeep_t      us_tkeep;
    logic        us_tlast;
    tuser_t      us_tuser;
    logic        ds_tvalid;
    logic        ds_tready;
    tdata_t      ds_tdata;
    tkeep_t      ds_tkeep;
    logic        ds_tlast;
    tuser_t      ds_tuser;
    logic        bypass_active;

    beat_t       exp_q[$];
    logic        in_acc    = 1'b0;
    logic        in_sop    = 1'b1;
    logic        in_mode   = 1'b0;
    int          errors    = 0;
    int          checked   = 0;
    int          cycles    = 0;
    int unsigned ready_pct = 100;
    string       test_name = "reset_check";

    axi4s_bypass_stage u_dut (.*);

    initial begin
        axi4s_if_from_tx = 1'b0;
        forever #50 axi4s_if_from_tx = ~axi4s_if_from_tx;
    end

    // ==============================
    // Reference model
    // ==============================
    // Processing mode folds a null closing beat into the beat before it
    task automatic model_input();
        beat_t b;
        beat_t t;
        b = '{tdata: us_tdata, tkeep: us_tkeep, tlast: us_tlast, tuser: us_tuser};
        if (in_sop) begin
            in_mode = bypass_active;
        end
        if (!in_mode && !in_sop && b.tlast && b.tkeep == '0 && exp_q.size() > 0) begin
            t = exp_q.pop_back();
            t.tlast = 1'b1;
            exp_q.push_back(t);
        end else begin
            exp_q.push_back(b);
        end
        in_sop = b.tlast;
    endtask

    task automatic check_output();
        beat_t act;
        beat_t exp;
        act = '{tdata: ds_tdata, tkeep: ds_tkeep, tlast: ds_tlast, tuser: ds_tuser};
        checked++;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Unexpected output beat %h in %s while no beat was expected",
                     act, test_name);
        end else begin
            exp = exp_q.pop_front();
            assert (act == exp) else begin
                errors++;
                $display("Fail %s expected %h actual %h", test_name, exp, act);
            end
        end
    endtask

    // Sample just before the rising edge, where handshakes have settled
    initial begin
        forever begin
            @(negedge axi4s_if_from_tx);
            #40;
            in_acc = aresetn && us_tvalid && us_tready;
            if (in_acc) begin
                model_input();
            end
            if (aresetn && ds_tvalid && ds_tready) begin
                check_output();
            end
        end
    end

    initial begin
        ds_tready = 1'b0;
        forever begin
            @(negedge axi4s_if_from_tx);
            ds_tready = ($urandom % 100) < ready_pct;
        end
    end

    always @(posedge axi4s_if_from_tx) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    task automatic send_packet(input int len, input logic with_null);
        for (int i = 0; i < len; i++) begin
            us_tdata  = tdata_t'($urandom);
            us_tkeep  = tkeep_t'($urandom) | tkeep_t'(1);
            us_tuser  = tuser_t'($urandom);
            us_tlast  = (i == len - 1);
            if (with_null && i == len - 1) begin
                us_tkeep = '0;
            end
            us_tvalid = 1'b1;
            do @(negedge axi4s_if_from_tx); while (!in_acc);
            us_tvalid = 1'b0;
            if (($urandom % 4) == 0) begin
                @(negedge axi4s_if_from_tx);
            end
        end
    endtask

    // mode 0 processing, 1 bypass, 2 random path per packet
    task automatic run_test(input string name, input int mode, input int unsigned pct);
        int          len;
        int          err0;
        int          chk0;
        int unsigned afail0;
        test_name = name;
        ready_pct = pct;
        err0      = errors;
        chk0      = checked;
        afail0    = u_dut.u_assert.fail_cnt;
        if (mode < 2) begin
            bypass = (mode == 1);
        end
        for (int p = 0; p < N_PKTS; p++) begin
            len = 1 + int'($urandom % MAX_LEN);
            if (mode == 2) begin
                bypass = ($urandom % 2) == 1;
            end
            send_packet(len, len > 1 && ($urandom % 3) == 0);
        end
        while (exp_q.size() != 0) begin
            @(negedge axi4s_if_from_tx);
        end
        repeat (4) @(negedge axi4s_if_from_tx);
        $display("%s: %0d beats checked, %0d errors", name, checked - chk0,
                 errors - err0 + int'(u_dut.u_assert.fail_cnt - afail0));
    endtask

    initial begin
        int total;
        void'($urandom(32'h091b_db13));
        aresetn   = 1'b1;
        bypass    = 1'b0;
        us_tvalid = 1'b0;
        us_tdata  = '0;
        us_tkeep  = '0;
        us_tlast  = 1'b0;
        us_tuser  = '0;
        // Clean falling edge for the asynchronous reset
        #1 aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge axi4s_if_from_tx);
        @(negedge axi4s_if_from_tx);
        aresetn = 1'b1;
        repeat (2) @(negedge axi4s_if_from_tx);
        $display("reset_check: %0d errors", u_dut.u_assert.fail_cnt);

        run_test("proc_path", 0, 100);
        run_test("bypass_path", 1, 100);
        run_test("switch_paths", 2, 80);
        run_test("back_pressure", 2, 30);

        total = errors + int'(u_dut.u_assert.fail_cnt);
        $display("Summary: 5 tests, %0d beats checked, %0d errors", checked, total);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_axi4s_bypass_stage

`default_nettype wire

// File: tb.f
axi4s_stage_pkg.sv
axi4s_beat_if.sv
stream_reg_slice.sv
null_tlast_trimmer.sv
inflight_pkt_counter.sv
path_select_fsm.sv
stream_path_mux.sv
axi4s_bypass_stage.sv
tb_axi4s_bypass_stage_assert.sv
tb_axi4s_bypass_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the bypass stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_axi4s_bypass_stage \
    -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim +verilator+error+limit+100000 > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error" >&2; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
